// ==== design/udp_echo_filter.sv ====
// Matches UDP headers against the echo port, builds the reply header and steers payload
`timescale 1ns/1ps

module udp_echo_filter
    import udp_echo_pkg::*;
#(
    parameter udp_port_t ECHO_PORT = DEF_ECHO_PORT
) (
    input  logic              clk,
    input  logic              rst,

    // Inbound header from the UDP stack
    input  logic              rx_hdr_valid,
    output logic              rx_hdr_ready,
    input  ip_addr_t          rx_src_ip,
    input  udp_port_t         rx_src_port,
    input  udp_port_t         rx_dest_port,
    input  udp_len_t          rx_length,

    // Outbound reply header
    input  logic              tx_hdr_ready,
    output logic              tx_hdr_valid,
    output ip_addr_t          tx_dest_ip,
    output udp_port_t         tx_src_port,
    output udp_port_t         tx_dest_port,
    output udp_len_t          tx_length,

    // Inbound payload
    input  logic [DATA_W-1:0] rx_tdata,
    input  logic [KEEP_W-1:0] rx_tkeep,
    input  logic              rx_tvalid,
    input  logic              rx_tlast,
    input  logic              rx_tuser,
    output logic              rx_tready,

    // Echoed payload toward the FIFO
    udp_stream_if.src         out
);

    filter_state_e state;
    filter_state_e state_next;
    logic          match;
    logic          idle;
    logic          hdr_accept;
    logic          beat_xfer;

    assign idle  = (state == FILT_IDLE);
    assign match = (rx_dest_port == ECHO_PORT);

    // Header path is purely combinational
    assign tx_hdr_valid = idle && rx_hdr_valid && match;
    // Non-matching headers are swallowed at once
    assign rx_hdr_ready = idle && (match ? tx_hdr_ready : 1'b1);
    assign hdr_accept   = rx_hdr_valid && rx_hdr_ready;

    // Reply goes back to the sender with ports swapped
    assign tx_dest_ip   = rx_src_ip;
    assign tx_src_port  = rx_dest_port;
    assign tx_dest_port = rx_src_port;
    assign tx_length    = rx_length;

    // Payload beats pass straight through
    assign out.tdata  = rx_tdata;
    assign out.tkeep  = rx_tkeep;
    assign out.tlast  = rx_tlast;
    assign out.tuser  = rx_tuser;
    assign out.tvalid = rx_tvalid && (state == FILT_FORWARD);

    always_comb begin
        case (state)
            FILT_FORWARD: rx_tready = out.tready;
            FILT_DROP:    rx_tready = 1'b1;
            default:      rx_tready = 1'b0;
        endcase
    end

    assign beat_xfer = rx_tvalid && rx_tready;

    always_comb begin
        state_next = state;
        case (state)
            FILT_IDLE: begin
                if (hdr_accept) begin
                    state_next = match ? FILT_FORWARD : FILT_DROP;
                end
            end
            FILT_FORWARD, FILT_DROP: begin
                // Frame ends on the last payload beat
                if (beat_xfer && rx_tlast) begin
                    state_next = FILT_IDLE;
                end
            end
            default: state_next = FILT_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FILT_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // A reply header is only offered between frames
    a_hdr_only_idle: assert property (@(posedge clk) disable iff (rst)
        tx_hdr_valid |-> state == FILT_IDLE)
        else $error("tx_hdr_valid raised outside FILT_IDLE");

    // Payload never moves before its header is taken
    a_no_payload_idle: assert property (@(posedge clk) disable iff (rst)
        state == FILT_IDLE |-> !rx_tready)
        else $error("rx_tready high in FILT_IDLE");

endmodule

// ==== design/udp_echo_pkg.sv ====
// Shared widths, header field types, filter states and default parameters for the UDP echo engine
package udp_echo_pkg;

    // Payload stream geometry
    localparam int DATA_W = 64;
    localparam int KEEP_W = DATA_W / 8;

    // Parsed UDP/IP header fields
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;
    typedef logic [15:0] udp_len_t;

    // Per-frame payload steering in the filter
    typedef enum logic [1:0] {
        FILT_IDLE    = 2'd0,  // waiting for a header
        FILT_FORWARD = 2'd1,  // payload goes to the FIFO
        FILT_DROP    = 2'd2   // payload is consumed and discarded
    } filter_state_e;

    // Destination port that triggers an echo
    localparam udp_port_t DEF_ECHO_PORT = 16'd1234;

    // Echo FIFO depth in payload beats, power of two
    localparam int DEF_FIFO_DEPTH = 16;

endpackage

// ==== design/udp_echo_top.sv ====
// UDP echo engine top level placed between a UDP stack's receive and transmit sides
`timescale 1ns/1ps

module udp_echo_top
    import udp_echo_pkg::*;
#(
    parameter udp_port_t ECHO_PORT  = DEF_ECHO_PORT,
    parameter int        FIFO_DEPTH = DEF_FIFO_DEPTH
) (
    input  logic              clk,
    input  logic              rst,

    // Received header
    input  logic              rx_hdr_valid,
    output logic              rx_hdr_ready,
    input  ip_addr_t          rx_src_ip,
    input  udp_port_t         rx_src_port,
    input  udp_port_t         rx_dest_port,
    input  udp_len_t          rx_length,

    // Reply header
    input  logic              tx_hdr_ready,
    output logic              tx_hdr_valid,
    output ip_addr_t          tx_dest_ip,
    output udp_port_t         tx_src_port,
    output udp_port_t         tx_dest_port,
    output udp_len_t          tx_length,

    // Received payload
    input  logic [DATA_W-1:0] rx_tdata,
    input  logic [KEEP_W-1:0] rx_tkeep,
    input  logic              rx_tvalid,
    input  logic              rx_tlast,
    input  logic              rx_tuser,
    output logic              rx_tready,

    // Echoed payload
    output logic [DATA_W-1:0] tx_tdata,
    output logic [KEEP_W-1:0] tx_tkeep,
    output logic              tx_tvalid,
    output logic              tx_tlast,
    output logic              tx_tuser,
    input  logic              tx_tready,

    output logic [7:0]        led
);

    logic tx_xfer;
    logic first_beat;

    udp_stream_if filt_to_fifo ();

    udp_echo_filter #(
        .ECHO_PORT (ECHO_PORT)
    ) udp_echo_filter_i (
        .clk          (clk),
        .rst          (rst),
        .rx_hdr_valid (rx_hdr_valid),
        .rx_hdr_ready (rx_hdr_ready),
        .rx_src_ip    (rx_src_ip),
        .rx_src_port  (rx_src_port),
        .rx_dest_port (rx_dest_port),
        .rx_length    (rx_length),
        .tx_hdr_ready (tx_hdr_ready),
        .tx_hdr_valid (tx_hdr_valid),
        .tx_dest_ip   (tx_dest_ip),
        .tx_src_port  (tx_src_port),
        .tx_dest_port (tx_dest_port),
        .tx_length    (tx_length),
        .rx_tdata     (rx_tdata),
        .rx_tkeep     (rx_tkeep),
        .rx_tvalid    (rx_tvalid),
        .rx_tlast     (rx_tlast),
        .rx_tuser     (rx_tuser),
        .rx_tready    (rx_tready),
        .out          (filt_to_fifo.src)
    );

    udp_payload_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) udp_payload_fifo_i (
        .clk       (clk),
        .rst       (rst),
        .in        (filt_to_fifo.sink),
        .tx_tdata  (tx_tdata),
        .tx_tkeep  (tx_tkeep),
        .tx_tvalid (tx_tvalid),
        .tx_tlast  (tx_tlast),
        .tx_tuser  (tx_tuser),
        .tx_tready (tx_tready)
    );

    assign tx_xfer = tx_tvalid && tx_tready;

    // First beat of each transmitted frame drives the LEDs
    always_ff @(posedge clk) begin
        if (rst) begin
            first_beat <= 1'b1;
            led        <= '0;
        end else if (tx_xfer) begin
            first_beat <= tx_tlast;
            if (first_beat) begin
                led <= tx_tdata[7:0];
            end
        end
    end

endmodule

// ==== design/udp_payload_fifo.sv ====
// Circular-buffer FIFO holding echoed payload beats until the transmit side takes them
`timescale 1ns/1ps

module udp_payload_fifo
    import udp_echo_pkg::*;
#(
    parameter int FIFO_DEPTH = DEF_FIFO_DEPTH
) (
    input  logic              clk,
    input  logic              rst,

    udp_stream_if.sink        in,

    output logic [DATA_W-1:0] tx_tdata,
    output logic [KEEP_W-1:0] tx_tkeep,
    output logic              tx_tvalid,
    output logic              tx_tlast,
    output logic              tx_tuser,
    input  logic              tx_tready
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    // One stored beat, all sideband kept alongside the data
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [KEEP_W-1:0] keep;
        logic              last;
        logic              user;
    } beat_t;

    beat_t            mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             wr_en;
    logic             rd_en;

    assign in.tready = (count != (PTR_W+1)'(FIFO_DEPTH));
    assign tx_tvalid = (count != '0);

    assign wr_en = in.tvalid && in.tready;
    assign rd_en = tx_tvalid && tx_tready;

    // Head of queue shown directly
    assign tx_tdata = mem[rd_ptr].data;
    assign tx_tkeep = mem[rd_ptr].keep;
    assign tx_tlast = mem[rd_ptr].last;
    assign tx_tuser = mem[rd_ptr].user;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= '{data: in.tdata, keep: in.tkeep, last: in.tlast, user: in.tuser};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Writer and reader respect occupancy from the previous edge
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        in.tvalid && count == (PTR_W+1)'(FIFO_DEPTH) |-> !wr_en)
        else $error("FIFO write while full");

    a_no_underflow: assert property (@(posedge clk) disable iff (rst)
        count == '0 |-> !rd_en)
        else $error("FIFO read while empty");

    a_count_bound: assert property (@(posedge clk) disable iff (rst)
        count <= (PTR_W+1)'(FIFO_DEPTH))
        else $error("FIFO count above depth");

endmodule

// ==== design/udp_stream_if.sv ====
// Valid/ready payload stream bundle used between the echo filter and the payload FIFO
`timescale 1ns/1ps

interface udp_stream_if
    import udp_echo_pkg::*;
();

    logic [DATA_W-1:0] tdata;
    logic [KEEP_W-1:0] tkeep;
    logic              tvalid;
    logic              tready;
    logic              tlast;
    logic              tuser;   // Error flag, travels with the beat

    modport src (
        output tdata, tkeep, tvalid, tlast, tuser,
        input  tready
    );

    modport sink (
        input  tdata, tkeep, tvalid, tlast, tuser,
        output tready
    );

endinterface

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the UDP echo testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module udp_echo_tb \
    -f vlog.f \
    -o udp_echo_sim

./obj_dir/udp_echo_sim

// ==== tb/udp_echo_tb.sv ====
// Testbench for the UDP echo engine that drives random echo and drop frames and checks them with assertions
`timescale 1ns/1ps

module udp_echo_tb
    import udp_echo_pkg::*;
();

    localparam udp_port_t   ECHO_PORT      = DEF_ECHO_PORT;
    localparam int          FIFO_DEPTH     = DEF_FIFO_DEPTH;
    localparam logic [31:0] SEED           = 32'hcd1deae0;
    localparam int          NUM_FRAMES     = 40;
    localparam int          MAX_BEATS      = 24;
    // Worst case per frame is a full frame at heavy stalls plus header wait
    localparam int          TIMEOUT_CYCLES = (NUM_FRAMES + 1) * MAX_BEATS * 20 + 320;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [KEEP_W-1:0] keep;
        logic              last;
        logic              user;
    } beat_t;

    logic clk = 1'b0;
    logic rst;
    logic rx_hdr_valid, rx_hdr_ready, tx_hdr_ready, tx_hdr_valid;
    ip_addr_t  rx_src_ip, tx_dest_ip;
    udp_port_t rx_src_port, rx_dest_port, tx_src_port, tx_dest_port;
    udp_len_t  rx_length, tx_length;
    logic [DATA_W-1:0] rx_tdata, tx_tdata;
    logic [KEEP_W-1:0] rx_tkeep, tx_tkeep;
    logic rx_tvalid, rx_tlast, rx_tuser, rx_tready;
    logic tx_tvalid, tx_tlast, tx_tuser, tx_tready;
    logic [7:0] led;

    // Scoreboard and reference state
    beat_t       exp_q[$];
    beat_t       exp_head;
    int          exp_cnt;
    logic [7:0]  exp_led;
    logic        tx_first;
    logic        full_seen = 1'b0;
    logic        hdr_seen, fwd_phase, drop_phase, hold_tx;
    logic [31:0] rng, stall_rng;
    int          cycles = 0;
    int          drop_count = 0;

    udp_echo_top #(
        .ECHO_PORT  (ECHO_PORT),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) udp_echo_top_i (
        .clk          (clk),
        .rst          (rst),
        .rx_hdr_valid (rx_hdr_valid),
        .rx_hdr_ready (rx_hdr_ready),
        .rx_src_ip    (rx_src_ip),
        .rx_src_port  (rx_src_port),
        .rx_dest_port (rx_dest_port),
        .rx_length    (rx_length),
        .tx_hdr_ready (tx_hdr_ready),
        .tx_hdr_valid (tx_hdr_valid),
        .tx_dest_ip   (tx_dest_ip),
        .tx_src_port  (tx_src_port),
        .tx_dest_port (tx_dest_port),
        .tx_length    (tx_length),
        .rx_tdata     (rx_tdata),
        .rx_tkeep     (rx_tkeep),
        .rx_tvalid    (rx_tvalid),
        .rx_tlast     (rx_tlast),
        .rx_tuser     (rx_tuser),
        .rx_tready    (rx_tready),
        .tx_tdata     (tx_tdata),
        .tx_tkeep     (tx_tkeep),
        .tx_tvalid    (tx_tvalid),
        .tx_tlast     (tx_tlast),
        .tx_tuser     (tx_tuser),
        .tx_tready    (tx_tready),
        .led          (led)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic draw_rand(output logic [31:0] r);
        rng = lcg_step(rng);
        r = rng;
    endtask

    task automatic report_fail(input string msg);
        $display("FAIL %0t: %s", $time, msg);
        $display("FAIL: see errors above");
        $fatal(1, "check failed");
    endtask

    // Sends a header and its payload between drive points 2 ns after a rising edge
    task automatic send_frame(input logic echo, input int beats);
        logic [31:0] r;
        draw_rand(r);
        rx_src_ip = r;
        draw_rand(r);
        rx_src_port  = r[15:0];
        rx_dest_port = echo ? ECHO_PORT : r[31:16];
        if (!echo && rx_dest_port == ECHO_PORT) begin
            rx_dest_port = ECHO_PORT ^ 16'h0001;
        end
        rx_length    = 16'(8 + 8 * beats);
        rx_hdr_valid = 1'b1;
        hdr_seen     = 1'b1;
        @(negedge clk);
        while (!rx_hdr_ready) @(negedge clk);
        @(posedge clk);
        #2;
        rx_hdr_valid = 1'b0;
        fwd_phase    = echo;
        drop_phase   = !echo;
        for (int i = 0; i < beats; i++) begin
            draw_rand(r);
            rx_tdata[63:32] = r;
            draw_rand(r);
            rx_tdata[31:0] = r;
            rx_tlast  = (i == beats - 1);
            rx_tkeep  = rx_tlast ? ({KEEP_W{1'b1}} >> r[2:0]) : {KEEP_W{1'b1}};
            rx_tuser  = rx_tlast && (r[7:5] == 3'd0);
            rx_tvalid = 1'b1;
            @(negedge clk);
            while (!rx_tready) @(negedge clk);
            @(posedge clk);
            #2;
        end
        rx_tvalid  = 1'b0;
        rx_tlast   = 1'b0;
        fwd_phase  = 1'b0;
        drop_phase = 1'b0;
    endtask

    // Downstream readiness is random unless held off
    initial begin
        tx_tready    = 1'b0;
        tx_hdr_ready = 1'b0;
        stall_rng    = ~SEED;
        forever begin
            @(posedge clk);
            #2;
            stall_rng    = lcg_step(stall_rng);
            tx_tready    = !hold_tx && (stall_rng[31:30] != 2'b00);
            tx_hdr_ready = (stall_rng[29:28] != 2'b00);
        end
    end

    // Reference model of FIFO contents and LED
    always @(posedge clk) begin
        if (rst) begin
            exp_q.delete();
            exp_cnt  <= 0;
            exp_head <= '0;
            exp_led  <= 8'h00;
            tx_first <= 1'b1;
        end else begin
            if (tx_tvalid && tx_tready && exp_q.size() != 0) begin
                if (tx_first) begin
                    exp_led <= exp_q[0].data[7:0];
                end
                tx_first <= exp_q[0].last;
                void'(exp_q.pop_front());
            end
            if (fwd_phase && rx_tvalid && rx_tready) begin
                exp_q.push_back('{data: rx_tdata, keep: rx_tkeep, last: rx_tlast, user: rx_tuser});
            end
            if (fwd_phase && exp_cnt == FIFO_DEPTH && !rx_tready) begin
                full_seen <= 1'b1;
            end
            exp_cnt <= exp_q.size();
            if (exp_q.size() != 0) begin
                exp_head <= exp_q[0];
            end else begin
                exp_head <= '0;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("FAIL: see errors above");
            $fatal(1, "timeout");
        end
    end

    a_quiet: assert property (@(posedge clk) disable iff (rst)
        !hdr_seen |-> !tx_hdr_valid && !tx_tvalid && !rx_tready && led == 8'h00)
        else report_fail("outputs active before any header");

    a_echo_hdr: assert property (@(posedge clk) disable iff (rst)
        rx_hdr_valid && rx_dest_port == ECHO_PORT |-> tx_hdr_valid
        && tx_dest_ip == rx_src_ip && tx_src_port == rx_dest_port
        && tx_dest_port == rx_src_port && tx_length == rx_length
        && rx_hdr_ready == tx_hdr_ready)
        else report_fail("reply header wrong for echo header");

    a_other_hdr: assert property (@(posedge clk) disable iff (rst)
        rx_hdr_valid && rx_dest_port != ECHO_PORT |-> !tx_hdr_valid && rx_hdr_ready)
        else report_fail("non-echo header not swallowed");

    a_no_hdr: assert property (@(posedge clk) disable iff (rst)
        !rx_hdr_valid |-> !tx_hdr_valid)
        else report_fail("tx_hdr_valid without an inbound header");

    a_idle_ready: assert property (@(posedge clk) disable iff (rst)
        !fwd_phase && !drop_phase |-> !rx_tready)
        else report_fail("rx_tready high between frames");

    a_drop_ready: assert property (@(posedge clk) disable iff (rst)
        drop_phase |-> rx_tready)
        else report_fail("rx_tready low while dropping");

    // Back-pressure tracks FIFO occupancy exactly
    a_fwd_ready: assert property (@(posedge clk) disable iff (rst)
        fwd_phase |-> rx_tready == (exp_cnt < FIFO_DEPTH))
        else report_fail("rx_tready does not match FIFO occupancy");

    a_tx_beat: assert property (@(posedge clk) disable iff (rst)
        tx_tvalid |-> exp_cnt != 0 && tx_tdata == exp_head.data
        && tx_tkeep == exp_head.keep && tx_tlast == exp_head.last
        && tx_tuser == exp_head.user)
        else report_fail("tx beat differs from expected beat");

    a_led: assert property (@(posedge clk) disable iff (rst)
        led == exp_led)
        else report_fail("led differs from first byte of last echoed frame");

    initial begin
        logic [31:0] r;
        logic        echo;
        int          beats;
        rst          = 1'b1;
        rx_hdr_valid = 1'b0;
        rx_src_ip    = '0;
        rx_src_port  = '0;
        rx_dest_port = '0;
        rx_length    = '0;
        rx_tdata     = '0;
        rx_tkeep     = '0;
        rx_tvalid    = 1'b0;
        rx_tlast     = 1'b0;
        rx_tuser     = 1'b0;
        hdr_seen     = 1'b0;
        fwd_phase    = 1'b0;
        drop_phase   = 1'b0;
        hold_tx      = 1'b0;
        rng          = SEED;
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;
        // Quiet stretch before the first header
        repeat (6) @(posedge clk);
        #2;
        for (int f = 0; f < NUM_FRAMES; f++) begin
            draw_rand(r);
            echo  = (f == 0) || r[0];
            beats = 1 + int'(r[15:8]) % MAX_BEATS;
            send_frame(echo, beats);
            if (!echo) begin
                drop_count++;
            end
            if (r[20]) begin
                @(posedge clk);
                #2;
            end
        end
        // Long frame against a stalled transmit side
        hold_tx = 1'b1;
        fork
            send_frame(1'b1, MAX_BEATS);
            begin
                wait (full_seen);
                repeat (8) @(posedge clk);
                #2;
                hold_tx = 1'b0;
            end
        join
        while (exp_cnt != 0) begin
            @(posedge clk);
            #2;
        end
        repeat (4) @(posedge clk);
        if (drop_count == 0) begin
            report_fail("random frames never took the drop path");
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule

// ==== vlog.f ====
design/udp_echo_pkg.sv
design/udp_stream_if.sv
design/udp_echo_filter.sv
design/udp_payload_fifo.sv
design/udp_echo_top.sv
tb/udp_echo_tb.sv
